/* Bender.yml */
package:
  name: msg_subsys

sources:
  - src/msg_pkg.sv
  - src/msg_packer.sv
  - src/msg_fifo.sv
  - src/msg_intake.sv
  - src/msg_absorber.sv
  - src/msg_subsys_top.sv
  - target: test
    files:
      - testbench/tb_msg_subsys.sv

/* flist.f */
src/msg_pkg.sv
src/msg_packer.sv
src/msg_fifo.sv
src/msg_intake.sv
src/msg_absorber.sv
src/msg_subsys_top.sv
testbench/tb_msg_subsys.sv

/* src/msg_absorber.sv */
////////////////////////////////////////
// Absorber that drains message words at a fixed rate
// Waits AbsorbGap cycles after every pop
// Digest is an XOR fold standing in for sponge state
////////////////////////////////////////
`timescale 1ns/1ps

module msg_absorber #(
  parameter int AbsorbGap = 1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      msg_valid_i,
  input  msg_pkg::msg_word_t        msg_word_i,
  output logic                      msg_ready_o,
  input  logic                      clear_i,
  output logic [msg_pkg::LenW-1:0]  msg_len_o,
  output logic [msg_pkg::DataW-1:0] digest_o
);
  import msg_pkg::*;

  // One spare state so a zero gap still gets a legal width
  localparam int GapW = $clog2(AbsorbGap + 2);

  logic [GapW-1:0] gap_q;
  logic            pop;

  assign msg_ready_o = (gap_q == '0);
  assign pop         = msg_valid_i && msg_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gap_q     <= '0;
      msg_len_o <= '0;
      digest_o  <= '0;
    end else begin
      // Pacing counter
      if (pop) begin
        gap_q <= GapW'(AbsorbGap);
      end else if (gap_q != '0) begin
        gap_q <= gap_q - 1'b1;
      end
      // Clear wins over a pop in the totals
      if (clear_i) begin
        msg_len_o <= '0;
        digest_o  <= '0;
      end else if (pop) begin
        msg_len_o <= msg_len_o + LenW'(strb_pop(msg_word_i.strb));
        digest_o  <= digest_o ^ lane_mask(msg_word_i.data, msg_word_i.strb);
      end
    end
  end

  // A waiting word stays put until it is popped
  MsgHold_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    msg_valid_i && !msg_ready_o && !clear_i |=> msg_valid_i && $stable(msg_word_i));

endmodule

/* src/msg_fifo.sv */
////////////////////////////////////////
// Synchronous FIFO for packed message words
// No pass-through, read data lags a write by one cycle
// clr_i empties the FIFO in one cycle
////////////////////////////////////////
`timescale 1ns/1ps

module msg_fifo #(
  parameter  int MsgDepth = 9,
  localparam int DepthW   = $clog2(MsgDepth + 1)
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clr_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  input  msg_pkg::msg_word_t wdata_i,
  output logic               rvalid_o,
  input  logic               rready_i,
  output msg_pkg::msg_word_t rdata_o,
  output logic               full_o,
  output logic [DepthW-1:0]  depth_o
);
  import msg_pkg::*;

  localparam int PtrW = $clog2(MsgDepth);

  msg_word_t         mem [MsgDepth];
  logic [PtrW-1:0]   wr_ptr_q, rd_ptr_q;
  logic [DepthW-1:0] cnt_q;
  logic              push, pop;

  assign full_o   = (cnt_q == DepthW'(MsgDepth));
  assign wready_o = !full_o;
  assign rvalid_o = (cnt_q != '0);
  assign push     = wvalid_i && wready_o;
  assign pop      = rvalid_o && rready_i;

  // Pointers wrap at MsgDepth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(MsgDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(MsgDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && !clr_i) begin
      mem[wr_ptr_q] <= wdata_i;
    end
  end

  assign rdata_o = mem[rd_ptr_q];
  assign depth_o = cnt_q;

  // Occupancy bound
  DepthMax_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= DepthW'(MsgDepth));

  // Writer holds its word while the FIFO is full
  FullHold_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wvalid_i && full_o && !rready_i && !clr_i |=> wvalid_i);

endmodule

/* src/msg_intake.sv */
////////////////////////////////////////
// Message intake with packer, FIFO and flush FSM
// process_i is honored only in idle
// Input is refused from process_i until clear_i
// clear_i is a level, acted on once the flush ends
////////////////////////////////////////
`timescale 1ns/1ps

module msg_intake #(
  parameter  int MsgDepth = 9,
  localparam int DepthW   = $clog2(MsgDepth + 1)
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               in_valid_i,
  input  msg_pkg::msg_word_t in_word_i,
  output logic               in_ready_o,
  output logic               msg_valid_o,
  output msg_pkg::msg_word_t msg_word_o,
  input  logic               msg_ready_i,
  output logic               fifo_empty_o,
  output logic               fifo_full_o,
  output logic [DepthW-1:0]  fifo_depth_o,
  input  logic               process_i,
  input  logic               clear_i,
  output logic               process_o
);
  import msg_pkg::*;

  flush_st_e flush_st, flush_st_d;
  logic      idle;
  logic      pk_in_ready, pk_flush, pk_flush_done;
  logic      pk_valid, pk_ready;
  msg_word_t pk_word;
  logic      fifo_clr;

  assign idle = (flush_st == FlushIdle);

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Input only flows in idle
  assign in_ready_o = pk_in_ready && idle;
  assign pk_flush   = process_i && idle;
  assign fifo_clr   = clear_i && (flush_st == FlushClear);

  msg_packer u_packer (
    .clk_i,
    .rst_ni,
    .in_valid_i   (in_valid_i && idle),
    .in_word_i    (in_word_i),
    .in_ready_o   (pk_in_ready),
    .out_valid_o  (pk_valid),
    .out_word_o   (pk_word),
    .out_ready_i  (pk_ready),
    .flush_i      (pk_flush),
    .flush_done_o (pk_flush_done)
  );

  msg_fifo #(
    .MsgDepth (MsgDepth)
  ) u_fifo (
    .clk_i,
    .rst_ni,
    .clr_i    (fifo_clr),
    .wvalid_i (pk_valid),
    .wready_o (pk_ready),
    .wdata_i  (pk_word),
    .rvalid_o (msg_valid_o),
    .rready_i (msg_ready_i),
    .rdata_o  (msg_word_o),
    .full_o   (fifo_full_o),
    .depth_o  (fifo_depth_o)
  );

  assign fifo_empty_o = !msg_valid_o;

  ////////////////////////////////////////
  // Flush FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_st <= FlushIdle;
    end else begin
      flush_st <= flush_st_d;
    end
  end

  always_comb begin
    flush_st_d = flush_st;
    process_o  = 1'b0;
    unique case (flush_st)
      FlushIdle:   if (process_i) flush_st_d = FlushPacker;
      // Packer done means its last word sits in the FIFO
      FlushPacker: if (pk_flush_done) flush_st_d = FlushFifo;
      FlushFifo: begin
        if (fifo_empty_o) begin
          flush_st_d = FlushClear;
          process_o  = 1'b1;
        end
      end
      FlushClear:  if (clear_i) flush_st_d = FlushIdle;
      default:     flush_st_d = FlushIdle;
    endcase
  end

  // State stays legal
  FlushStKnown_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_st inside {FlushIdle, FlushPacker, FlushFifo, FlushClear});

  // No input taken while a flush is running
  NoInputInFlush_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !idle |-> !(in_valid_i && in_ready_o));

  // Packer done comes at least one cycle after the request
  FlushDoneLater_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({pk_flush, pk_flush_done}));

endmodule

/* src/msg_packer.sv */
////////////////////////////////////////
// Byte packer in front of the message FIFO
// Input strobes must be contiguous from lane 0
// Input is blocked while a flush is in progress
// flush_i must not repeat before flush_done_o
////////////////////////////////////////
`timescale 1ns/1ps

module msg_packer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               in_valid_i,
  input  msg_pkg::msg_word_t in_word_i,
  output logic               in_ready_o,
  output logic               out_valid_o,
  output msg_pkg::msg_word_t out_word_o,
  input  logic               out_ready_i,
  input  logic               flush_i,
  output logic               flush_done_o
);
  import msg_pkg::*;

  logic [DataW-1:0]   acc_q, acc_d;
  logic [CntW-1:0]    cnt_q, cnt_d;
  logic [CntW:0]      sum;
  logic [2*DataW-1:0] merged;
  logic               pend_q, pend_d;
  logic               done_q, done_d;
  logic               out_valid_q;
  msg_word_t          out_word_q, load_word;
  logic               load, out_free, flush_go, in_fire;

  // Output register is free when empty or drained this cycle
  assign out_free   = !out_valid_q || out_ready_i;
  assign flush_go   = flush_i || pend_q;
  assign in_ready_o = out_free && !flush_go;
  assign in_fire    = in_valid_i && in_ready_o;

  // New bytes land right above the pending ones
  assign sum    = {1'b0, cnt_q} + {1'b0, strb_pop(in_word_i.strb)};
  assign merged = {{DataW{1'b0}}, acc_q} |
                  ({{DataW{1'b0}}, lane_mask(in_word_i.data, in_word_i.strb)} << (8 * cnt_q));

  always_comb begin
    acc_d     = acc_q;
    cnt_d     = cnt_q;
    pend_d    = pend_q;
    done_d    = 1'b0;
    load      = 1'b0;
    load_word = '0;
    if (in_fire) begin
      if (sum >= WordBytes) begin
        // Full word goes out, spill-over stays behind
        load           = 1'b1;
        load_word.data = merged[DataW-1:0];
        load_word.strb = '1;
        acc_d          = merged[2*DataW-1:DataW];
        cnt_d          = CntW'(sum - WordBytes);
      end else begin
        acc_d = merged[DataW-1:0];
        cnt_d = CntW'(sum);
      end
    end else if (flush_go && out_free) begin
      if (cnt_q != '0) begin
        // Partial word, done follows once it is taken
        load           = 1'b1;
        load_word.data = acc_q;
        load_word.strb = lane_strb(cnt_q);
        acc_d          = '0;
        cnt_d          = '0;
        pend_d         = 1'b1;
      end else begin
        pend_d = 1'b0;
        done_d = 1'b1;
      end
    end else if (flush_i) begin
      pend_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q       <= '0;
      cnt_q       <= '0;
      pend_q      <= 1'b0;
      done_q      <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      acc_q  <= acc_d;
      cnt_q  <= cnt_d;
      pend_q <= pend_d;
      done_q <= done_d;
      if (load) begin
        out_valid_q <= 1'b1;
      end else if (out_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_word_q <= load_word;
    end
  end

  assign out_valid_o  = out_valid_q;
  assign out_word_o   = out_word_q;
  assign flush_done_o = done_q;

  // Packed strobes stay contiguous from lane 0
  StrbContig_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o |-> (out_word_o.strb != '0) &&
                    (((out_word_o.strb + 1'b1) & out_word_o.strb) == '0));

  // No second flush request while one is pending
  FlushOnce_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> !pend_q && !done_q);

endmodule

/* src/msg_pkg.sv */
////////////////////////////////////////
// Shared types for the message intake path
// Words are little endian, lane 0 carries the first byte
// Valid lanes are always contiguous from lane 0
////////////////////////////////////////
package msg_pkg;

  // Byte lanes per message word
  parameter int WordBytes = 8;
  parameter int DataW     = 8 * WordBytes;
  // Counts 0 to WordBytes lanes
  parameter int CntW      = $clog2(WordBytes + 1);
  // Running byte count width in the absorber
  parameter int LenW      = 32;

  typedef struct packed {
    logic [DataW-1:0]     data;
    logic [WordBytes-1:0] strb;  // one bit per byte lane
  } msg_word_t;

  // Flush sequencing from process_i to clear_i
  typedef enum logic [1:0] {
    FlushIdle,
    FlushPacker,
    FlushFifo,
    FlushClear
  } flush_st_e;

  // Number of strobed lanes
  function automatic logic [CntW-1:0] strb_pop(input logic [WordBytes-1:0] strb);
    logic [CntW-1:0] n;
    n = '0;
    for (int i = 0; i < WordBytes; i++) begin
      n = n + CntW'(strb[i]);
    end
    return n;
  endfunction

  // Zero the bytes of lanes without strobe
  function automatic logic [DataW-1:0] lane_mask(input logic [DataW-1:0]     data,
                                                 input logic [WordBytes-1:0] strb);
    logic [DataW-1:0] m;
    for (int i = 0; i < WordBytes; i++) begin
      m[8*i +: 8] = strb[i] ? data[8*i +: 8] : 8'h00;
    end
    return m;
  endfunction

  // Strobe covering the lowest cnt lanes
  function automatic logic [WordBytes-1:0] lane_strb(input logic [CntW-1:0] cnt);
    logic [WordBytes-1:0] s;
    for (int i = 0; i < WordBytes; i++) begin
      s[i] = (i < cnt);
    end
    return s;
  endfunction

endpackage

/* src/msg_subsys_top.sv */
////////////////////////////////////////
// Message subsystem top, intake feeding absorber
// MsgDepth of 2 or more, AbsorbGap of 0 or more
////////////////////////////////////////
`timescale 1ns/1ps

module msg_subsys_top #(
  parameter  int MsgDepth  = 9,
  parameter  int AbsorbGap = 1,
  localparam int DepthW    = $clog2(MsgDepth + 1)
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      in_valid_i,
  input  msg_pkg::msg_word_t        in_word_i,
  output logic                      in_ready_o,
  input  logic                      process_i,
  input  logic                      clear_i,
  output logic                      done_o,
  output logic                      fifo_empty_o,
  output logic                      fifo_full_o,
  output logic [DepthW-1:0]         fifo_depth_o,
  output logic [msg_pkg::LenW-1:0]  msg_len_o,
  output logic [msg_pkg::DataW-1:0] digest_o
);
  import msg_pkg::*;

  // Message channel between FIFO and absorber
  logic      msg_valid, msg_ready;
  msg_word_t msg_word;

  msg_intake #(
    .MsgDepth (MsgDepth)
  ) u_intake (
    .clk_i,
    .rst_ni,
    .in_valid_i   (in_valid_i),
    .in_word_i    (in_word_i),
    .in_ready_o   (in_ready_o),
    .msg_valid_o  (msg_valid),
    .msg_word_o   (msg_word),
    .msg_ready_i  (msg_ready),
    .fifo_empty_o (fifo_empty_o),
    .fifo_full_o  (fifo_full_o),
    .fifo_depth_o (fifo_depth_o),
    .process_i    (process_i),
    .clear_i      (clear_i),
    .process_o    (done_o)
  );

  msg_absorber #(
    .AbsorbGap (AbsorbGap)
  ) u_absorber (
    .clk_i,
    .rst_ni,
    .msg_valid_i (msg_valid),
    .msg_word_i  (msg_word),
    .msg_ready_o (msg_ready),
    .clear_i     (clear_i),
    .msg_len_o   (msg_len_o),
    .digest_o    (digest_o)
  );

endmodule

/* testbench/tb_msg_subsys.sv */
////////////////////////////////////////
// Testbench for the message subsystem
// DUT runs with default MsgDepth and AbsorbGap
// Inputs change 2 ns after the rising edge
// Outputs are read at the falling edge
// Concurrent assertions compare against a byte model
////////////////////////////////////////
`timescale 1ns/1ps

module tb_msg_subsys;
  import msg_pkg::*;

  localparam int  MsgDepth  = 9;
  localparam int  DepthW    = $clog2(MsgDepth + 1);
  localparam time DrvDly    = 2ns;
  localparam int  WaitLimit = 2000;

  logic                clk_i;
  logic                rst_ni;
  logic                in_valid_i;
  msg_word_t           in_word_i;
  logic                in_ready_o;
  logic                process_i;
  logic                clear_i;
  logic                done_o;
  logic                fifo_empty_o;
  logic                fifo_full_o;
  logic [DepthW-1:0]   fifo_depth_o;
  logic [LenW-1:0]     msg_len_o;
  logic [DataW-1:0]    digest_o;

  // Reference model state
  logic [LenW-1:0]     exp_len;
  logic [DataW-1:0]    exp_digest;
  int                  stream_off;

  // Phase flags that arm the checks
  logic chk_idle;
  logic whole_words;
  logic burst_on;
  logic flushing;
  logic seen_full;

  msg_subsys_top dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_word_i    (in_word_i),
    .in_ready_o   (in_ready_o),
    .process_i    (process_i),
    .clear_i      (clear_i),
    .done_o       (done_o),
    .fifo_empty_o (fifo_empty_o),
    .fifo_full_o  (fifo_full_o),
    .fifo_depth_o (fifo_depth_o),
    .msg_len_o    (msg_len_o),
    .digest_o     (digest_o)
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("Error at %0t: %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
    stop_run();
  endtask

  task automatic plain_error(input string what);
    $display("Failure at %0t: %s", $time, what);
    stop_run();
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Quiet state right after reset
  IdleFlags_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_idle |-> !done_o && fifo_empty_o && in_ready_o)
    else plain_error("after reset done_o, fifo_empty_o or in_ready_o has the wrong level");
  IdleLen_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_idle |-> msg_len_o == '0)
    else value_error("msg_len_o", 64'd0, 64'($sampled(msg_len_o)));
  IdleDigest_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_idle |-> digest_o == '0)
    else value_error("digest_o", 64'd0, $sampled(digest_o));

  // Totals at done match the model
  DoneLen_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> msg_len_o == exp_len)
    else value_error("msg_len_o", 64'($sampled(exp_len)), 64'($sampled(msg_len_o)));
  DoneDigest_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> digest_o == exp_digest)
    else value_error("digest_o", $sampled(exp_digest), $sampled(digest_o));
  DonePulse_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else plain_error("done_o stayed high for more than one cycle");
  WholeWords_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o && whole_words |-> msg_len_o[2:0] == 3'd0)
    else value_error("msg_len_o[2:0]", 64'd0, 64'($sampled(msg_len_o[2:0])));

  // Back-pressure while the input is held valid
  FullBlocks_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    burst_on && in_valid_i && fifo_full_o |-> !in_ready_o)
    else plain_error("in_ready_o was high while the FIFO was full");
  DepthMax_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_depth_o <= DepthW'(MsgDepth))
    else value_error("fifo_depth_o", 64'(MsgDepth), 64'($sampled(fifo_depth_o)));

  // Input closed from process_i until clear_i
  FlushBlocks_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flushing |-> !in_ready_o)
    else plain_error("in_ready_o went high during a flush");
  ClearLen_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> msg_len_o == '0)
    else value_error("msg_len_o", 64'd0, 64'($sampled(msg_len_o)));
  ClearDigest_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> digest_o == '0)
    else value_error("digest_o", 64'd0, $sampled(digest_o));

  always @(negedge clk_i) begin
    if (rst_ni && burst_on && fifo_full_o) begin
      seen_full <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #DrvDly;
  endtask

  // Append the strobed bytes of one word to the model
  task automatic model_append(input msg_word_t w, input int nb);
    for (int i = 0; i < nb; i++) begin
      exp_digest = exp_digest ^ (DataW'(w.data[8*i +: 8]) << (8 * (stream_off % 8)));
      stream_off = stream_off + 1;
      exp_len    = exp_len + 1;
    end
  endtask

  task automatic send_word(input msg_word_t w, input int nb);
    int   waited;
    logic fire;
    waited     = 0;
    fire       = 1'b0;
    in_valid_i = 1'b1;
    in_word_i  = w;
    while (!fire) begin
      @(negedge clk_i);
      fire = in_ready_o;
      if (fire) begin
        model_append(w, nb);
      end
      next_cycle();
      waited++;
      if (!fire && waited > WaitLimit) begin
        plain_error("input word was never accepted");
      end
    end
  endtask

  // Random strobe widths unless full words are asked for
  task automatic send_message(input int nbytes, input bit full, input bit gaps);
    int        remaining;
    int        width;
    int        gap;
    msg_word_t w;
    remaining = nbytes;
    while (remaining > 0) begin
      width = full ? 8 : 1 + int'($urandom % 8);
      if (width > remaining) begin
        width = remaining;
      end
      w.data = {$urandom, $urandom};
      w.strb = 8'hFF >> (8 - width);
      send_word(w, width);
      remaining = remaining - width;
      if (gaps) begin
        gap        = int'($urandom % 3);
        in_valid_i = 1'b0;
        repeat (gap) next_cycle();
      end
    end
    in_valid_i = 1'b0;
  endtask

  // Pulse process_i, wait for done_o and then clear
  task automatic flush_and_clear();
    int   waited;
    logic found;
    waited    = 0;
    found     = 1'b0;
    flushing  = 1'b1;
    process_i = 1'b1;
    next_cycle();
    process_i = 1'b0;
    while (!found) begin
      @(negedge clk_i);
      found = done_o;
      next_cycle();
      waited++;
      if (!found && waited > WaitLimit) begin
        plain_error("done_o did not pulse after process_i");
      end
    end
    clear_i = 1'b1;
    next_cycle();
    clear_i     = 1'b0;
    flushing    = 1'b0;
    whole_words = 1'b0;
    exp_len     = '0;
    exp_digest  = '0;
    stream_off  = 0;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(27));
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    in_valid_i  = 1'b0;
    in_word_i   = '0;
    process_i   = 1'b0;
    clear_i     = 1'b0;
    exp_len     = '0;
    exp_digest  = '0;
    stream_off  = 0;
    chk_idle    = 1'b0;
    whole_words = 1'b0;
    burst_on    = 1'b0;
    flushing    = 1'b0;
    seen_full   = 1'b0;

    repeat (16) @(posedge clk_i);
    #DrvDly;
    rst_ni   = 1'b1;
    chk_idle = 1'b1;
    next_cycle();
    chk_idle = 1'b0;

    // Random messages with valid gaps
    repeat (4) begin
      send_message(1 + int'($urandom % 60), 1'b0, 1'b1);
      flush_and_clear();
    end

    // Whole words with random and then full strobes
    whole_words = 1'b1;
    send_message(24, 1'b0, 1'b1);
    flush_and_clear();
    whole_words = 1'b1;
    send_message(16, 1'b1, 1'b0);
    flush_and_clear();

    // Continuous full words fill the FIFO
    burst_on = 1'b1;
    send_message(320, 1'b1, 1'b0);
    burst_on = 1'b0;
    flush_and_clear();
    assert (seen_full) else plain_error("fifo_full_o never went high during the burst");

    // One more message after the last clear
    send_message(1 + int'($urandom % 60), 1'b0, 1'b1);
    flush_and_clear();

    repeat (4) next_cycle();
    $display("all tests passed");
    $finish;
  end

endmodule
